// File: common/csr_pkg.sv
// ================================================
// CSR file shared definitions
// ================================================
package csr_pkg;

  localparam int xlen       = 32;
  localparam int csr_addr_w = 12;
  localparam int cause_w    = 4;
  localparam int cnt_w      = 64;  // full width of cycle and instret
  localparam int n_ext_irq  = 8;

  typedef logic [xlen-1:0] csr_data_t;

  typedef enum logic [csr_addr_w-1:0] {
    addr_mstatus   = 12'h300,
    addr_misa      = 12'h301,
    addr_mie       = 12'h304,
    addr_mtvec     = 12'h305,
    addr_mscratch  = 12'h340,
    addr_mepc      = 12'h341,
    addr_mcause    = 12'h342,
    addr_mtval     = 12'h343,
    addr_mip       = 12'h344,
    addr_mcycle    = 12'hB00,
    addr_minstret  = 12'hB02,
    addr_mcycleh   = 12'hB80,
    addr_minstreth = 12'hB82,
    addr_cycle     = 12'hC00,
    addr_instret   = 12'hC02,
    addr_cycleh    = 12'hC80,
    addr_instreth  = 12'hC82,
    addr_mvendorid = 12'hF11,
    addr_marchid   = 12'hF12,
    addr_mimpid    = 12'hF13,
    addr_mhartid   = 12'hF14
  } csr_addr_e;

  // bit 2 marks an access, bits 1:0 the kind of write
  typedef enum logic [2:0] {
    cmd_idle  = 3'b000,
    cmd_read  = 3'b100,
    cmd_write = 3'b101,
    cmd_set   = 3'b110,
    cmd_clear = 3'b111
  } csr_cmd_e;

  typedef enum logic [1:0] {
    priv_user    = 2'b00,
    priv_machine = 2'b11
  } priv_e;

  // top bit is the interrupt flag so that shared code values stay apart
  typedef enum logic [cause_w:0] {
    cause_inst_misaligned  = 5'h00,
    cause_inst_fault       = 5'h01,
    cause_illegal_inst     = 5'h02,
    cause_breakpoint       = 5'h03,
    cause_load_misaligned  = 5'h04,
    cause_load_fault       = 5'h05,
    cause_store_misaligned = 5'h06,
    cause_store_fault      = 5'h07,
    irq_software           = 5'h13,
    irq_timer              = 5'h17,
    irq_external           = 5'h1B
  } mcause_e;

  typedef struct packed {
    csr_cmd_e              cmd;
    logic [csr_addr_w-1:0] addr;
    csr_data_t             wdata;
  } csr_req_t;

  typedef struct packed {
    logic               exception;
    logic               is_int;
    logic [cause_w-1:0] code;
    csr_data_t          pc;
    csr_data_t          mem_addr;
    csr_data_t          inst;
  } trap_req_t;

  typedef struct packed {
    logic                  wen;
    logic [csr_addr_w-1:0] addr;
    csr_data_t             data;
  } csr_wr_t;

  // mstatus and mip field positions
  localparam int mstatus_mie  = 3;
  localparam int mstatus_mpie = 7;
  localparam int mstatus_mpp  = 11;
  localparam int mip_msip     = 3;
  localparam int mip_mtip     = 7;
  localparam int mip_meip     = 11;

  localparam csr_data_t mtvec_reset = 32'h8000_0000;
  localparam csr_data_t mepc_reset  = 32'h0000_0080;

  localparam csr_data_t vendor_id  = 32'd0;
  localparam csr_data_t arch_id    = 32'd31;
  localparam csr_data_t impl_id    = 32'd1;
  localparam csr_data_t hart_id    = 32'd0;
  localparam csr_data_t misa_value = 32'h4010_1100;  // rv32 with i, m and u

endpackage

// File: rtl/csr_access_ctrl.sv
// ================================================
// CSR access decode and check
// ================================================
module csr_access_ctrl (
  input  csr_pkg::csr_req_t  csr_req,
  input  csr_pkg::priv_e     prv,
  input  csr_pkg::csr_data_t rdata,
  input  logic               defined,
  output logic               illegal_access,
  output csr_pkg::csr_wr_t   csr_wr
);

  logic               is_access;
  logic               is_write;
  logic               ro_region;
  logic               priv_low;
  csr_pkg::csr_data_t wr_data;

  // ================================================
  // command decode and legality
  // ================================================
  assign is_access = (csr_req.cmd != csr_pkg::cmd_idle);
  assign is_write  = csr_req.cmd inside {csr_pkg::cmd_write, csr_pkg::cmd_set,
                                         csr_pkg::cmd_clear};

  assign ro_region = (csr_req.addr[11:10] == 2'b11);   // 0xC00 and up
  assign priv_low  = (csr_req.addr[9:8] > prv);        // address needs more privilege

  assign illegal_access = is_access && (!defined || (is_write && ro_region) || priv_low);

  // ================================================
  // write data for set and clear
  // ================================================
  always_comb begin
    case (csr_req.cmd)
      csr_pkg::cmd_set:   wr_data = rdata | csr_req.wdata;
      csr_pkg::cmd_clear: wr_data = rdata & ~csr_req.wdata;
      default:            wr_data = csr_req.wdata;
    endcase
  end

  // an illegal access never reaches the storage blocks
  assign csr_wr.wen  = is_write && !illegal_access;
  assign csr_wr.addr = csr_req.addr;
  assign csr_wr.data = wr_data;

endmodule

// File: rtl/csr_trap_unit.sv
// ================================================
// Trap state and privilege stack
// ================================================
module csr_trap_unit (
  input  logic               clk,
  input  logic               nreset,
  input  csr_pkg::csr_wr_t   csr_wr,
  input  csr_pkg::trap_req_t trap,
  input  logic               mret,
  output csr_pkg::priv_e     prv,
  output csr_pkg::csr_data_t mstatus,
  output logic               mie_bit,
  output csr_pkg::csr_data_t mtvec,
  output csr_pkg::csr_data_t mscratch,
  output csr_pkg::csr_data_t mepc,
  output csr_pkg::csr_data_t mcause,
  output csr_pkg::csr_data_t mtval,
  output csr_pkg::csr_data_t handler_pc
);

  csr_pkg::priv_e   mpp;
  logic             mpie;
  logic             wr_mstatus;
  csr_pkg::mcause_e trap_cause;

  assign wr_mstatus = csr_wr.wen && (csr_wr.addr == csr_pkg::addr_mstatus);
  assign trap_cause = csr_pkg::mcause_e'({trap.is_int, trap.code});

  // single handler, vectored mode not supported
  assign handler_pc = mtvec;

  always_comb begin
    mstatus                                 = '0;
    mstatus[csr_pkg::mstatus_mpp +: 2]      = mpp;
    mstatus[csr_pkg::mstatus_mpie]          = mpie;
    mstatus[csr_pkg::mstatus_mie]           = mie_bit;
  end

  // ================================================
  // privilege and mstatus stack
  // ================================================
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      prv     <= csr_pkg::priv_machine;
      mpp     <= csr_pkg::priv_user;
      mpie    <= 1'b0;
      mie_bit <= 1'b0;
    end else if (wr_mstatus) begin
      if (csr_wr.data[csr_pkg::mstatus_mpp +: 2] != 2'b10) begin  // reserved level
        mpp <= csr_pkg::priv_e'(csr_wr.data[csr_pkg::mstatus_mpp +: 2]);
      end
      mpie    <= csr_wr.data[csr_pkg::mstatus_mpie];
      mie_bit <= csr_wr.data[csr_pkg::mstatus_mie];
    end else if (trap.exception) begin
      prv     <= csr_pkg::priv_machine;
      mpp     <= prv;
      mpie    <= mie_bit;
      mie_bit <= 1'b0;
    end else if (mret) begin
      prv     <= mpp;
      mpp     <= csr_pkg::priv_user;
      mie_bit <= mpie;
      mpie    <= 1'b1;
    end
  end

  // ================================================
  // trap registers
  // ================================================
  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      mtvec    <= csr_pkg::mtvec_reset;
      mscratch <= '0;
      mepc     <= csr_pkg::mepc_reset;
      mcause   <= '0;
      mtval    <= '0;
    end else begin
      if (trap.exception) begin
        mepc   <= {trap.pc[csr_pkg::xlen-1:1], 1'b0};
        mcause <= {trap.is_int, {(csr_pkg::xlen-csr_pkg::cause_w-1){1'b0}}, trap.code};
        case (trap_cause)
          csr_pkg::cause_inst_misaligned,
          csr_pkg::cause_inst_fault:       mtval <= trap.pc;
          csr_pkg::cause_load_misaligned,
          csr_pkg::cause_load_fault,
          csr_pkg::cause_store_misaligned,
          csr_pkg::cause_store_fault:      mtval <= trap.mem_addr;
          csr_pkg::cause_illegal_inst:     mtval <= trap.inst;
          default: ;                                  // interrupts keep mtval
        endcase
      end
      // a write lands after the trap update so it wins on the same register
      if (csr_wr.wen) begin
        case (csr_wr.addr)
          csr_pkg::addr_mtvec:    mtvec    <= {csr_wr.data[csr_pkg::xlen-1:2], 2'b00};
          csr_pkg::addr_mscratch: mscratch <= csr_wr.data;
          csr_pkg::addr_mepc:     mepc     <= csr_wr.data;
          csr_pkg::addr_mcause:   mcause   <= csr_wr.data;
          csr_pkg::addr_mtval:    mtval    <= csr_wr.data;
          default: ;
        endcase
      end
    end
  end

endmodule

// File: rtl/csr_counters.sv
// ================================================
// Cycle and instret counters
// ================================================
module csr_counters (
  input  logic                      clk,
  input  logic                      nreset,
  input  csr_pkg::csr_wr_t          csr_wr,
  input  logic                      retire,
  output logic [csr_pkg::cnt_w-1:0] cycle,
  output logic [csr_pkg::cnt_w-1:0] instret
);

  logic [csr_pkg::cnt_w-1:0] count [2];  // 0 is cycle, 1 is instret
  logic [1:0]                step;

  assign step    = {retire, 1'b1};       // cycle steps on every edge
  assign cycle   = count[0];
  assign instret = count[1];

  // only the machine addresses reach here, user aliases are read only
  for (genvar i = 0; i < 2; i++) begin : g_count
    localparam csr_pkg::csr_addr_e lo_addr =
      (i == 0) ? csr_pkg::addr_mcycle : csr_pkg::addr_minstret;
    localparam csr_pkg::csr_addr_e hi_addr =
      (i == 0) ? csr_pkg::addr_mcycleh : csr_pkg::addr_minstreth;

    logic wr_lo;
    logic wr_hi;

    assign wr_lo = csr_wr.wen && (csr_wr.addr == lo_addr);
    assign wr_hi = csr_wr.wen && (csr_wr.addr == hi_addr);

    always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
        count[i] <= '0;
      end else if (wr_lo) begin
        count[i][csr_pkg::xlen-1:0] <= csr_wr.data;
      end else if (wr_hi) begin
        count[i][csr_pkg::cnt_w-1:csr_pkg::xlen] <= csr_wr.data;
      end else if (step[i]) begin
        count[i] <= count[i] + 1'b1;
      end
    end
  end

endmodule

// File: rtl/csr_irq_ctrl.sv
// ================================================
// Machine interrupt control
// ================================================
module csr_irq_ctrl (
  input  logic                          clk,
  input  logic                          nreset,
  input  csr_pkg::csr_wr_t              csr_wr,
  input  logic                          timer_tick,
  input  logic [csr_pkg::n_ext_irq-1:0] ext_irq,
  input  csr_pkg::priv_e                prv,
  input  logic                          mie_bit,
  output csr_pkg::csr_data_t            mip,
  output logic                          interrupt_pending,
  output logic                          interrupt_taken,
  output csr_pkg::mcause_e              interrupt_code
);

  logic msip;   // software pending, the only writable bit
  logic mtip;
  logic meip;

  always_ff @(posedge clk or negedge nreset) begin
    if (!nreset) begin
      msip <= 1'b0;
      mtip <= 1'b0;
      meip <= 1'b0;
    end else if (csr_wr.wen && (csr_wr.addr == csr_pkg::addr_mip)) begin
      msip <= csr_wr.data[csr_pkg::mip_msip];  // timer and external hold this cycle
    end else begin
      mtip <= timer_tick;
      meip <= |ext_irq;
    end
  end

  always_comb begin
    mip                    = '0;
    mip[csr_pkg::mip_msip] = msip;
    mip[csr_pkg::mip_mtip] = mtip;
    mip[csr_pkg::mip_meip] = meip;
  end

  assign interrupt_pending = |mip;

  // user mode cannot mask machine interrupts
  always_comb begin
    case (prv)
      csr_pkg::priv_user:    interrupt_taken = interrupt_pending;
      csr_pkg::priv_machine: interrupt_taken = interrupt_pending && mie_bit;
      default:               interrupt_taken = 1'b0;
    endcase
  end

  assign interrupt_code = mtip ? csr_pkg::irq_timer    :
                          meip ? csr_pkg::irq_external : csr_pkg::irq_software;

endmodule

// File: rtl/csr_read_mux.sv
// ================================================
// CSR read port
// ================================================
module csr_read_mux (
  input  logic [csr_pkg::csr_addr_w-1:0] addr,
  input  csr_pkg::csr_data_t             mstatus,
  input  csr_pkg::csr_data_t             mtvec,
  input  csr_pkg::csr_data_t             mscratch,
  input  csr_pkg::csr_data_t             mepc,
  input  csr_pkg::csr_data_t             mcause,
  input  csr_pkg::csr_data_t             mtval,
  input  csr_pkg::csr_data_t             mip,
  input  logic [csr_pkg::cnt_w-1:0]      cycle,
  input  logic [csr_pkg::cnt_w-1:0]      instret,
  output csr_pkg::csr_data_t             rdata,
  output logic                           defined
);

  localparam int lo = csr_pkg::xlen;  // split point of the 64-bit counters

  always_comb begin
    rdata   = '0;
    defined = 1'b1;
    case (addr)
      csr_pkg::addr_mstatus:   rdata = mstatus;
      csr_pkg::addr_misa:      rdata = csr_pkg::misa_value;
      csr_pkg::addr_mie:       rdata = '0;   // only the global enable in mstatus
      csr_pkg::addr_mtvec:     rdata = mtvec;
      csr_pkg::addr_mscratch:  rdata = mscratch;
      csr_pkg::addr_mepc:      rdata = mepc;
      csr_pkg::addr_mcause:    rdata = mcause;
      csr_pkg::addr_mtval:     rdata = mtval;
      csr_pkg::addr_mip:       rdata = mip;

      // machine counters and their user aliases
      csr_pkg::addr_mcycle,
      csr_pkg::addr_cycle:     rdata = cycle[lo-1:0];
      csr_pkg::addr_mcycleh,
      csr_pkg::addr_cycleh:    rdata = cycle[csr_pkg::cnt_w-1:lo];
      csr_pkg::addr_minstret,
      csr_pkg::addr_instret:   rdata = instret[lo-1:0];
      csr_pkg::addr_minstreth,
      csr_pkg::addr_instreth:  rdata = instret[csr_pkg::cnt_w-1:lo];

      csr_pkg::addr_mvendorid: rdata = csr_pkg::vendor_id;
      csr_pkg::addr_marchid:   rdata = csr_pkg::arch_id;
      csr_pkg::addr_mimpid:    rdata = csr_pkg::impl_id;
      csr_pkg::addr_mhartid:   rdata = csr_pkg::hart_id;
      default:                 defined = 1'b0;
    endcase
  end

endmodule

// File: rtl/csr_file_top.sv
// ================================================
// Machine mode CSR file
// ================================================
module csr_file_top (
  input  logic                            clk,
  input  logic                            nreset,
  input  csr_pkg::csr_req_t               csr_req,
  input  csr_pkg::trap_req_t              trap,
  input  logic                            mret,
  input  logic                            retire,
  input  logic                            timer_tick,
  input  logic [csr_pkg::n_ext_irq-1:0]   ext_irq,
  output csr_pkg::csr_data_t              rdata,
  output logic                            illegal_access,
  output csr_pkg::priv_e                  prv,
  output csr_pkg::csr_data_t              handler_pc,
  output csr_pkg::csr_data_t              mepc,
  output logic                            interrupt_pending,
  output logic                            interrupt_taken,
  output csr_pkg::mcause_e                interrupt_code
);

  logic                      defined;
  csr_pkg::csr_wr_t          csr_wr;      // legal write, seen by every storage block
  csr_pkg::csr_data_t        mstatus;
  logic                      mie_bit;
  csr_pkg::csr_data_t        mtvec;
  csr_pkg::csr_data_t        mscratch;
  csr_pkg::csr_data_t        mcause;
  csr_pkg::csr_data_t        mtval;
  csr_pkg::csr_data_t        mip;
  logic [csr_pkg::cnt_w-1:0] cycle;
  logic [csr_pkg::cnt_w-1:0] instret;

  csr_access_ctrl csr_access_ctrl_i (
    .csr_req        (csr_req),
    .prv            (prv),
    .rdata          (rdata),
    .defined        (defined),
    .illegal_access (illegal_access),
    .csr_wr         (csr_wr)
  );

  csr_trap_unit csr_trap_unit_i (
    .clk        (clk),
    .nreset     (nreset),
    .csr_wr     (csr_wr),
    .trap       (trap),
    .mret       (mret),
    .prv        (prv),
    .mstatus    (mstatus),
    .mie_bit    (mie_bit),
    .mtvec      (mtvec),
    .mscratch   (mscratch),
    .mepc       (mepc),
    .mcause     (mcause),
    .mtval      (mtval),
    .handler_pc (handler_pc)
  );

  csr_counters csr_counters_i (
    .clk     (clk),
    .nreset  (nreset),
    .csr_wr  (csr_wr),
    .retire  (retire),
    .cycle   (cycle),
    .instret (instret)
  );

  csr_irq_ctrl csr_irq_ctrl_i (
    .clk               (clk),
    .nreset            (nreset),
    .csr_wr            (csr_wr),
    .timer_tick        (timer_tick),
    .ext_irq           (ext_irq),
    .prv               (prv),
    .mie_bit           (mie_bit),
    .mip               (mip),
    .interrupt_pending (interrupt_pending),
    .interrupt_taken   (interrupt_taken),
    .interrupt_code    (interrupt_code)
  );

  csr_read_mux csr_read_mux_i (
    .addr     (csr_req.addr),
    .mstatus  (mstatus),
    .mtvec    (mtvec),
    .mscratch (mscratch),
    .mepc     (mepc),
    .mcause   (mcause),
    .mtval    (mtval),
    .mip      (mip),
    .cycle    (cycle),
    .instret  (instret),
    .rdata    (rdata),
    .defined  (defined)
  );

endmodule

// File: bench/csr_clock_gen.sv
// ================================================
// Testbench clock and reset
// ================================================
module csr_clock_gen (
  output logic clk,
  output logic nreset
);

  localparam int half_period = 50;
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  initial begin
    nreset = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    nreset <= 1'b1;  // released on an edge, flops still see reset there
  end

endmodule

// File: bench/csr_file_checker.sv
// ================================================
// Trap unit assertions
// ================================================
module csr_file_checker (
  input logic               clk,
  input logic               nreset,
  input csr_pkg::csr_wr_t   csr_wr,
  input csr_pkg::trap_req_t trap,
  input csr_pkg::priv_e     prv,
  input logic               mie_bit,
  input csr_pkg::csr_data_t handler_pc
);

  logic trap_only;  // trap without an mstatus write in the same cycle

  assign trap_only = trap.exception &&
                     !(csr_wr.wen && (csr_wr.addr == csr_pkg::addr_mstatus));

  trap_enters_machine: assert property (
    @(posedge clk) disable iff (!nreset) trap_only |=> (prv == csr_pkg::priv_machine)
  ) else $error("privilege is not machine one cycle after a trap");

  trap_masks_mie: assert property (
    @(posedge clk) disable iff (!nreset) trap_only |=> !mie_bit
  ) else $error("MIE is still set one cycle after a trap");

  handler_aligned: assert property (
    @(posedge clk) disable iff (!nreset) (handler_pc[1:0] == 2'b00)
  ) else $error("handler address has its low two bits set");

endmodule

// File: bench/csr_file_tb.sv
// ================================================
// CSR file random testbench
// ================================================
module csr_file_tb;

  localparam int n_cycles   = 3000;
  localparam int clk_period = 100;
  localparam int drive_skew = 10;
  localparam int timeout    = (n_cycles + 8 + 20) * clk_period;

  logic                          clk;
  logic                          nreset;
  csr_pkg::csr_req_t             csr_req;
  csr_pkg::trap_req_t            trap;
  logic                          mret;
  logic                          retire;
  logic                          timer_tick;
  logic [csr_pkg::n_ext_irq-1:0] ext_irq;
  csr_pkg::csr_data_t            rdata;
  logic                          illegal_access;
  csr_pkg::priv_e                prv;
  csr_pkg::csr_data_t            handler_pc;
  csr_pkg::csr_data_t            mepc;
  logic                          interrupt_pending;
  logic                          interrupt_taken;
  csr_pkg::mcause_e              interrupt_code;

  integer      seed;
  logic [11:0] addr_list [21];
  logic [4:0]  cause_list [11];  // {is_int, code}

  // ================================================
  // reference model state
  // ================================================
  logic [1:0]         m_prv;
  logic [1:0]         m_mpp;
  logic               m_mpie;
  logic               m_mie;
  csr_pkg::csr_data_t m_mtvec;
  csr_pkg::csr_data_t m_mscratch;
  csr_pkg::csr_data_t m_mepc;
  csr_pkg::csr_data_t m_mcause;
  csr_pkg::csr_data_t m_mtval;
  logic [63:0]        m_cycle;
  logic [63:0]        m_instret;
  logic               m_msip;
  logic               m_mtip;
  logic               m_meip;

  csr_clock_gen csr_clock_gen_i (
    .clk    (clk),
    .nreset (nreset)
  );

  csr_file_top csr_file_top_i (
    .clk               (clk),
    .nreset            (nreset),
    .csr_req           (csr_req),
    .trap              (trap),
    .mret              (mret),
    .retire            (retire),
    .timer_tick        (timer_tick),
    .ext_irq           (ext_irq),
    .rdata             (rdata),
    .illegal_access    (illegal_access),
    .prv               (prv),
    .handler_pc        (handler_pc),
    .mepc              (mepc),
    .interrupt_pending (interrupt_pending),
    .interrupt_taken   (interrupt_taken),
    .interrupt_code    (interrupt_code)
  );

  bind csr_trap_unit csr_file_checker csr_file_checker_i (
    .clk        (clk),
    .nreset     (nreset),
    .csr_wr     (csr_wr),
    .trap       (trap),
    .prv        (prv),
    .mie_bit    (mie_bit),
    .handler_pc (handler_pc)
  );

  // ================================================
  // compare tasks
  // ================================================
  task automatic stop_on_mismatch(input string msg);
    $display("CHECK FAILED at time %0t: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic check_data(input string what, input csr_pkg::csr_data_t got,
                            input csr_pkg::csr_data_t exp);
    if (got !== exp) stop_on_mismatch($sformatf("%s expected %h got %h", what, exp, got));
  endtask

  task automatic check_priv(input string what, input csr_pkg::priv_e got,
                            input csr_pkg::priv_e exp);
    if (got !== exp) stop_on_mismatch($sformatf("%s expected %0d got %0d", what, exp, got));
  endtask

  task automatic check_code(input string what, input csr_pkg::mcause_e got,
                            input csr_pkg::mcause_e exp);
    if (got !== exp) stop_on_mismatch($sformatf("%s expected %h got %h", what, exp, got));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) stop_on_mismatch($sformatf("%s expected %b got %b", what, exp, got));
  endtask

  // ================================================
  // model
  // ================================================
  function automatic csr_pkg::csr_data_t read_model(input logic [11:0] addr, output logic def);
    csr_pkg::csr_data_t d;
    d   = '0;
    def = 1'b1;
    case (addr)
      csr_pkg::addr_mstatus: begin
        d[12:11] = m_mpp;
        d[7]     = m_mpie;
        d[3]     = m_mie;
      end
      csr_pkg::addr_misa:      d = csr_pkg::misa_value;
      csr_pkg::addr_mie:       d = '0;
      csr_pkg::addr_mtvec:     d = m_mtvec;
      csr_pkg::addr_mscratch:  d = m_mscratch;
      csr_pkg::addr_mepc:      d = m_mepc;
      csr_pkg::addr_mcause:    d = m_mcause;
      csr_pkg::addr_mtval:     d = m_mtval;
      csr_pkg::addr_mip:       d = {20'd0, m_meip, 3'd0, m_mtip, 3'd0, m_msip, 3'd0};
      csr_pkg::addr_mcycle,
      csr_pkg::addr_cycle:     d = m_cycle[31:0];
      csr_pkg::addr_mcycleh,
      csr_pkg::addr_cycleh:    d = m_cycle[63:32];
      csr_pkg::addr_minstret,
      csr_pkg::addr_instret:   d = m_instret[31:0];
      csr_pkg::addr_minstreth,
      csr_pkg::addr_instreth:  d = m_instret[63:32];
      csr_pkg::addr_mvendorid: d = csr_pkg::vendor_id;
      csr_pkg::addr_marchid:   d = csr_pkg::arch_id;
      csr_pkg::addr_mimpid:    d = csr_pkg::impl_id;
      csr_pkg::addr_mhartid:   d = csr_pkg::hart_id;
      default:                 def = 1'b0;
    endcase
    return d;
  endfunction

  // read data, legality and write data of the request now on the bus
  task automatic eval_access(output csr_pkg::csr_data_t rd, output logic illegal,
                             output logic wen, output csr_pkg::csr_data_t wd);
    logic def;
    logic access;
    logic is_wr;
    rd      = read_model(csr_req.addr, def);
    access  = (csr_req.cmd != csr_pkg::cmd_idle);
    is_wr   = (csr_req.cmd == csr_pkg::cmd_write) || (csr_req.cmd == csr_pkg::cmd_set) ||
              (csr_req.cmd == csr_pkg::cmd_clear);
    illegal = access && (!def || (is_wr && (csr_req.addr[11:10] == 2'b11)) ||
                         (csr_req.addr[9:8] > m_prv));
    wen     = is_wr && !illegal;
    case (csr_req.cmd)
      csr_pkg::cmd_set:   wd = rd | csr_req.wdata;
      csr_pkg::cmd_clear: wd = rd & ~csr_req.wdata;
      default:            wd = csr_req.wdata;
    endcase
  endtask

  task automatic reset_model;
    m_prv      = 2'b11;
    m_mpp      = 2'b00;
    m_mpie     = 1'b0;
    m_mie      = 1'b0;
    m_mtvec    = csr_pkg::mtvec_reset;
    m_mscratch = '0;
    m_mepc     = csr_pkg::mepc_reset;
    m_mcause   = '0;
    m_mtval    = '0;
    m_cycle    = '0;
    m_instret  = '0;
    m_msip     = 1'b0;
    m_mtip     = 1'b0;
    m_meip     = 1'b0;
  endtask

  // one rising edge with the inputs that are held now
  task automatic step_model;
    csr_pkg::csr_data_t rd;
    csr_pkg::csr_data_t wd;
    logic               illegal;
    logic               wen;
    logic [11:0]        a;
    logic [4:0]         cause;
    eval_access(rd, illegal, wen, wd);
    a     = csr_req.addr;
    cause = {trap.is_int, trap.code};
    if (wen && (a == csr_pkg::addr_mstatus)) begin
      if (wd[12:11] != 2'b10) m_mpp = wd[12:11];
      m_mpie = wd[7];
      m_mie  = wd[3];
    end else if (trap.exception) begin
      m_mpp  = m_prv;
      m_prv  = 2'b11;
      m_mpie = m_mie;
      m_mie  = 1'b0;
    end else if (mret) begin
      m_prv  = m_mpp;
      m_mpp  = 2'b00;
      m_mie  = m_mpie;
      m_mpie = 1'b1;
    end
    if (trap.exception) begin
      m_mepc   = {trap.pc[31:1], 1'b0};
      m_mcause = {trap.is_int, 27'd0, trap.code};
      if (cause inside {5'h00, 5'h01}) m_mtval = trap.pc;
      else if (cause inside {[5'h04:5'h07]}) m_mtval = trap.mem_addr;
      else if (cause == 5'h02) m_mtval = trap.inst;
    end
    if (wen) begin
      case (a)
        csr_pkg::addr_mtvec:    m_mtvec    = wd & 32'hFFFF_FFFC;
        csr_pkg::addr_mscratch: m_mscratch = wd;
        csr_pkg::addr_mepc:     m_mepc     = wd;
        csr_pkg::addr_mcause:   m_mcause   = wd;
        csr_pkg::addr_mtval:    m_mtval    = wd;
        default: ;
      endcase
    end
    if (wen && (a == csr_pkg::addr_mcycle)) m_cycle[31:0] = wd;
    else if (wen && (a == csr_pkg::addr_mcycleh)) m_cycle[63:32] = wd;
    else m_cycle = m_cycle + 64'd1;
    if (wen && (a == csr_pkg::addr_minstret)) m_instret[31:0] = wd;
    else if (wen && (a == csr_pkg::addr_minstreth)) m_instret[63:32] = wd;
    else if (retire) m_instret = m_instret + 64'd1;
    if (wen && (a == csr_pkg::addr_mip)) begin
      m_msip = wd[3];
    end else begin
      m_mtip = timer_tick;
      m_meip = |ext_irq;
    end
  endtask

  task automatic compare_outputs;
    csr_pkg::csr_data_t rd;
    csr_pkg::csr_data_t wd;
    logic               illegal;
    logic               wen;
    logic               pend;
    logic               taken;
    csr_pkg::mcause_e   code;
    eval_access(rd, illegal, wen, wd);
    pend = m_msip | m_mtip | m_meip;
    case (m_prv)
      2'b00:   taken = pend;
      2'b11:   taken = pend && m_mie;
      default: taken = 1'b0;
    endcase
    if (m_mtip) code = csr_pkg::irq_timer;
    else if (m_meip) code = csr_pkg::irq_external;
    else code = csr_pkg::irq_software;
    check_data($sformatf("rdata of %h", csr_req.addr), rdata, rd);
    check_bit("illegal_access", illegal_access, illegal);
    check_priv("prv", prv, csr_pkg::priv_e'(m_prv));
    check_data("handler_pc", handler_pc, m_mtvec);
    check_data("mepc", mepc, m_mepc);
    check_bit("interrupt_pending", interrupt_pending, pend);
    check_bit("interrupt_taken", interrupt_taken, taken);
    check_code("interrupt_code", interrupt_code, code);
  endtask

  // ================================================
  // stimulus
  // ================================================
  task automatic drive_random;
    logic [31:0] r;
    logic [31:0] pick;
    logic [4:0]  cause;
    r    = $random(seed);
    pick = $random(seed);
    case (r[2:0])
      3'd0, 3'd1: csr_req.cmd = csr_pkg::cmd_idle;
      3'd2, 3'd3: csr_req.cmd = csr_pkg::cmd_read;
      3'd5:       csr_req.cmd = csr_pkg::cmd_set;
      3'd6:       csr_req.cmd = csr_pkg::cmd_clear;
      default:    csr_req.cmd = csr_pkg::cmd_write;
    endcase
    if (r[5:3] == 3'd0) csr_req.addr = pick[11:0];  // mostly undefined addresses
    else csr_req.addr = addr_list[pick % 21];
    csr_req.wdata = $random(seed);
    trap = '0;
    if (r[8:6] == 3'd0) begin
      cause          = cause_list[pick[31:16] % 11];
      trap.exception = 1'b1;
      trap.is_int    = cause[4];
      trap.code      = cause[3:0];
      trap.pc        = $random(seed);
      trap.mem_addr  = $random(seed);
      trap.inst      = $random(seed);
    end
    mret       = (r[11:9] == 3'd0);
    retire     = r[12];
    timer_tick = (r[14:13] == 2'd0);
    ext_irq    = (r[16:15] == 2'd0) ? r[31:24] : '0;
  endtask

  initial begin
    seed       = 38728;
    csr_req    = '0;
    trap       = '0;
    mret       = 1'b0;
    retire     = 1'b0;
    timer_tick = 1'b0;
    ext_irq    = '0;
    addr_list  = '{csr_pkg::addr_mstatus, csr_pkg::addr_misa, csr_pkg::addr_mie,
                   csr_pkg::addr_mtvec, csr_pkg::addr_mscratch, csr_pkg::addr_mepc,
                   csr_pkg::addr_mcause, csr_pkg::addr_mtval, csr_pkg::addr_mip,
                   csr_pkg::addr_mcycle, csr_pkg::addr_mcycleh, csr_pkg::addr_minstret,
                   csr_pkg::addr_minstreth, csr_pkg::addr_cycle, csr_pkg::addr_cycleh,
                   csr_pkg::addr_instret, csr_pkg::addr_instreth, csr_pkg::addr_mvendorid,
                   csr_pkg::addr_marchid, csr_pkg::addr_mimpid, csr_pkg::addr_mhartid};
    cause_list = '{5'h00, 5'h01, 5'h02, 5'h03, 5'h04, 5'h05, 5'h06, 5'h07,
                   5'h13, 5'h17, 5'h1B};
    wait (nreset === 1'b1);
    reset_model();
    for (int n = 0; n < n_cycles; n++) begin
      @(posedge clk);
      step_model();
      #(drive_skew);
      drive_random();
      #(clk_period / 2 - drive_skew);  // sample mid cycle
      compare_outputs();
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

  // watchdog
  initial begin
    #(timeout);
    $display("watchdog expired after %0d time units, the run did not finish", timeout);
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule

// File: tb.f
common/csr_pkg.sv
rtl/csr_access_ctrl.sv
rtl/csr_trap_unit.sv
rtl/csr_counters.sv
rtl/csr_irq_ctrl.sv
rtl/csr_read_mux.sv
rtl/csr_file_top.sv
bench/csr_clock_gen.sv
bench/csr_file_checker.sv
bench/csr_file_tb.sv

// File: Bender.yml
package:
  name: csr_file

sources:
  - common/csr_pkg.sv
  - rtl/csr_access_ctrl.sv
  - rtl/csr_trap_unit.sv
  - rtl/csr_counters.sv
  - rtl/csr_irq_ctrl.sv
  - rtl/csr_read_mux.sv
  - rtl/csr_file_top.sv
  - target: test
    files:
      - bench/csr_clock_gen.sv
      - bench/csr_file_checker.sv
      - bench/csr_file_tb.sv
